// File: all.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_receiver.sv
logic/uart_sender.sv
logic/byte_packer.sv
logic/word_accumulator.sv
logic/word_queue.sv
logic/word_serializer.sv
logic/board_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f all.f --top-module tb_top -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "PASS: all tests" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: bench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module tb_top import uart_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int NUM_WORDS = 40;
	localparam int NUM_FRAMES = NUM_WORDS * `UART_WORD_BYTES + 2;
	// worst case 14 bit periods per frame plus drain of the last reply
	localparam int WATCHDOG_NS = ((NUM_FRAMES * 14 + 160) * `UART_CLKS_PER_BIT + 10) * CLK_PERIOD;

	logic CLK;
	logic reset;
	logic sw_clear;
	logic uart_rx;
	logic uart_tx;
	led_status_t led;
	logic exp_strobe;
	word_t exp_sum;
	led_status_t exp_led;
	int value_errors;
	int led_errors;
	int idle_errors;
	int words_checked;
	logic [31:0] lfsr_state;

	board_top u_dut (.CLK(CLK), .reset(reset), .sw_clear(sw_clear), .uart_rx(uart_rx),
		.uart_tx(uart_tx), .led(led));

	tb_checker u_checker (.CLK(CLK), .reset(reset), .uart_tx(uart_tx), .led(led),
		.exp_strobe(exp_strobe), .exp_sum(exp_sum), .exp_led(exp_led),
		.value_errors(value_errors), .led_errors(led_errors), .idle_errors(idle_errors),
		.words_checked(words_checked));

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		logic [9:0] bits;
		bits = {stop_bit, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx <= bits[0];
			bits = bits >> 1;
			repeat (`UART_CLKS_PER_BIT) @(posedge CLK);
		end
	endtask

	task automatic idle_gap(input int n_bits);
		uart_rx <= 1'b1;
		repeat (n_bits * `UART_CLKS_PER_BIT) @(posedge CLK);
	endtask

	initial begin : stimulus
		logic [31:0] word_bits;
		word_t model_sum;
		led_status_t model_led;
		CLK = 1'b0;
		reset = 1'b1;
		sw_clear = 1'b0;
		uart_rx = 1'b1;
		exp_strobe = 1'b0;
		exp_sum = '0;
		exp_led = '0;
		lfsr_state = 32'he8ad_88a8;
		model_sum = '0;
		model_led = '0;
		repeat (5) @(posedge CLK);
		reset <= 1'b0;
		idle_gap(2);
		for (int w = 0; w < NUM_WORDS; w++) begin
			word_bits = random_bits(32);
			model_sum = model_sum + word_bits;
			for (int b = 0; b < `UART_WORD_BYTES; b++) begin
				// two frames with a low stop bit that the DUT drops
				if ((w == 7 || w == 23) && b == 2) begin
					send_frame(8'(random_bits(8)), 1'b0);
					idle_gap(1 + int'(random_bits(2)));
					model_led.frame_err = 1'b1;
				end
				send_frame(word_bits[7:0], 1'b1);
				word_bits = word_bits >> 8;
				if (b != `UART_WORD_BYTES - 1)
					idle_gap(1 + int'(random_bits(2)));
			end
			model_led.count = model_led.count + 3'd1;
			exp_strobe <= 1'b1;
			exp_sum <= model_sum;
			exp_led <= model_led;
			@(posedge CLK);
			exp_strobe <= 1'b0;
			idle_gap(1 + int'(random_bits(2)));
			if (w == 12 || w == 29) begin
				idle_gap(1);
				sw_clear <= 1'b1;
				@(posedge CLK);
				sw_clear <= 1'b0;
				model_sum = '0;
				model_led = '0;
			end
		end
		while (words_checked < NUM_WORDS)
			@(posedge CLK);
		// catch late or repeated words
		repeat (50 * `UART_CLKS_PER_BIT) @(posedge CLK);
		$display("words checked %0d, value errors %0d, led errors %0d, idle errors %0d",
			words_checked, value_errors, led_errors, idle_errors);
		if (value_errors + led_errors + idle_errors == 0 && words_checked == NUM_WORDS)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: the DUT did not return all %0d words in time", NUM_WORDS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module tb_checker import uart_pkg::*; (
	input  logic        CLK,
	input  logic        reset,
	input  logic        uart_tx,
	input  led_status_t led,
	input  logic        exp_strobe,
	input  word_t       exp_sum,
	input  led_status_t exp_led,
	output int          value_errors,
	output int          led_errors,
	output int          idle_errors,
	output int          words_checked
);

	localparam int CLKS = `UART_CLKS_PER_BIT;

	// expected sums and led state, one entry per completed RX word
	word_t exp_sums[$];
	led_status_t exp_leds[$];

	always @(negedge CLK) begin
		if (reset) begin
			idle_errors = 0;
		end else begin
			// nothing may move before the first word is in
			if (exp_sums.size() == 0 && (led != '0 || uart_tx !== 1'b1)) begin
				$display("[FAIL] %0t: before the first word led=%h tx=%b", $time, led, uart_tx);
				idle_errors = idle_errors + 1;
			end
			if (exp_strobe) begin
				exp_sums.push_back(exp_sum);
				exp_leds.push_back(exp_led);
			end
		end
	end

	initial begin : decode_tx
		word_t got;
		led_status_t led_at_start;
		value_errors = 0;
		led_errors = 0;
		words_checked = 0;
		got = '0;
		led_at_start = '0;
		forever begin
			for (int b = 0; b < `UART_WORD_BYTES; b++) begin
				do
					@(negedge CLK);
				while (reset || uart_tx !== 1'b0);
				if (b == 0)
					led_at_start = led;
				repeat (CLKS / 2 - 1) @(negedge CLK);
				if (uart_tx !== 1'b0) begin
					$display("TX start bit at %0t ns did not stay low", $time);
					value_errors++;
				end
				// bits and bytes both arrive lsb first
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS) @(negedge CLK);
					got = {uart_tx, got[31:1]};
				end
				repeat (CLKS) @(negedge CLK);
				if (uart_tx !== 1'b1) begin
					$display("TX stop bit at %0t ns was low", $time);
					value_errors++;
				end
			end
			if (words_checked >= exp_sums.size()) begin
				$display("TX sent word %h at %0t ns with no RX word behind it", got, $time);
				value_errors++;
			end else begin
				if (got !== exp_sums[words_checked]) begin
					$display("[FAIL] %0t: word %0d is %h, expected %h", $time, words_checked,
						got, exp_sums[words_checked]);
					value_errors++;
				end
				if (led_at_start !== exp_leds[words_checked]) begin
					$display("[FAIL] %0t: word %0d led is %h, expected %h", $time, words_checked,
						led_at_start, exp_leds[words_checked]);
					led_errors++;
				end
				words_checked++;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/board_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_top import uart_pkg::*; (
	input  logic        CLK,
	input  logic        reset,
	input  logic        sw_clear,
	input  logic        uart_rx,
	output logic        uart_tx,
	output led_status_t led
);

	rx_byte_t rx_byte;
	logic rx_strobe;
	word_t word;
	logic word_strobe;
	word_t sum_word;
	logic sum_strobe;
	word_t head;
	logic not_empty;
	logic pop;
	logic [7:0] send_byte;
	logic send_strobe;
	logic ready;

	// receive side
	uart_receiver u_receiver (.CLK(CLK), .reset(reset), .rx(uart_rx),
		.rx_byte(rx_byte), .rx_strobe(rx_strobe));

	byte_packer u_packer (.CLK(CLK), .reset(reset), .rx_byte(rx_byte),
		.rx_strobe(rx_strobe), .word(word), .word_strobe(word_strobe));

	word_accumulator u_accumulator (.CLK(CLK), .reset(reset), .clear(sw_clear),
		.word(word), .word_strobe(word_strobe), .frame_err(rx_byte.frame_err),
		.sum_word(sum_word), .sum_strobe(sum_strobe), .status(led));

	// transmit side
	word_queue u_queue (.CLK(CLK), .reset(reset), .push(sum_strobe),
		.push_word(sum_word), .pop(pop), .head(head), .not_empty(not_empty));

	word_serializer u_serializer (.CLK(CLK), .reset(reset), .head(head),
		.not_empty(not_empty), .ready(ready), .pop(pop),
		.send_byte(send_byte), .send_strobe(send_strobe));

	uart_sender u_sender (.CLK(CLK), .reset(reset), .send_byte(send_byte),
		.send_strobe(send_strobe), .tx(uart_tx), .ready(ready));

endmodule

`default_nettype wire

// File: logic/word_serializer.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module word_serializer import uart_pkg::*; (
	input  logic       CLK,
	input  logic       reset,
	input  word_t      head,
	input  logic       not_empty,
	input  logic       ready,
	output logic       pop,
	output logic [7:0] send_byte,
	output logic       send_strobe
);

	localparam int IW = $clog2(`UART_WORD_BYTES);
	localparam logic [IW-1:0] LAST_BYTE = IW'(`UART_WORD_BYTES - 1);

	word_t word_buf;
	logic busy;
	logic [IW-1:0] byte_idx;

	assign pop = !busy && not_empty;
	// sender drops ready the next cycle, so this is a single pulse
	assign send_strobe = busy && ready;
	assign send_byte = word_buf[{byte_idx, 3'b000} +: 8];

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy <= 1'b0;
			byte_idx <= '0;
		end else if (pop) begin
			busy <= 1'b1;
			byte_idx <= '0;
		end else if (send_strobe) begin
			if (byte_idx == LAST_BYTE)
				busy <= 1'b0;
			byte_idx <= byte_idx + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (pop)
			word_buf <= head;
	end

endmodule

`default_nettype wire

// File: logic/word_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module word_queue import uart_pkg::*; (
	input  logic  CLK,
	input  logic  reset,
	input  logic  push,
	input  word_t push_word,
	input  logic  pop,
	output word_t head,
	output logic  not_empty
);

	localparam int DEPTH = `UART_QUEUE_DEPTH;
	localparam int AW = $clog2(DEPTH);

	word_t mem [DEPTH];
	// extra msb tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic full;

	assign not_empty = (wr_ptr != rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign head = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge CLK) begin
		if (push && !full)
			mem[wr_ptr[AW-1:0]] <= push_word;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && not_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	no_overflow: assert property (@(posedge CLK) disable iff (reset) push |-> !full);
	no_underflow: assert property (@(posedge CLK) disable iff (reset) pop |-> not_empty);

endmodule

`default_nettype wire

// File: logic/word_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module word_accumulator import uart_pkg::*; (
	input  logic        CLK,
	input  logic        reset,
	input  logic        clear,
	input  word_t       word,
	input  logic        word_strobe,
	input  logic        frame_err,
	output word_t       sum_word,
	output logic        sum_strobe,
	output led_status_t status
);

	// clear wins over an incoming word
	always_ff @(posedge CLK) begin
		if (reset || clear) begin
			sum_word <= '0;
			sum_strobe <= 1'b0;
			status <= '0;
		end else begin
			sum_strobe <= word_strobe;
			if (word_strobe) begin
				// sum wraps mod 2^32 and count mod 8
				sum_word <= sum_word + word;
				status.count <= status.count + 1'b1;
			end
			if (frame_err)
				status.frame_err <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/byte_packer.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module byte_packer import uart_pkg::*; (
	input  logic     CLK,
	input  logic     reset,
	input  rx_byte_t rx_byte,
	input  logic     rx_strobe,
	output word_t    word,
	output logic     word_strobe
);

	localparam int CW = $clog2(`UART_WORD_BYTES);
	localparam logic [CW-1:0] LAST_BYTE = CW'(`UART_WORD_BYTES - 1);

	logic [CW-1:0] byte_count;
	logic good_byte;

	// bad stop bit drops the byte entirely
	assign good_byte = rx_strobe && !rx_byte.frame_err;

	always_ff @(posedge CLK) begin
		if (reset) begin
			byte_count <= '0;
			word_strobe <= 1'b0;
		end else begin
			word_strobe <= good_byte && (byte_count == LAST_BYTE);
			if (good_byte)
				byte_count <= (byte_count == LAST_BYTE) ? '0 : byte_count + 1'b1;
		end
	end

	// shift right so the first byte lands in 7:0
	always_ff @(posedge CLK) begin
		if (good_byte)
			word <= {rx_byte.data, word[$bits(word_t)-1:8]};
	end

endmodule

`default_nettype wire

// File: logic/uart_sender.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_sender (
	input  logic       CLK,
	input  logic       reset,
	input  logic [7:0] send_byte,
	input  logic       send_strobe,
	output logic       tx,
	output logic       ready
);

	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int TW = $clog2(CLKS);
	localparam logic [TW-1:0] FULL_BIT = TW'(CLKS - 1);

	logic busy;
	logic [9:0] frame;
	logic [TW-1:0] timer;
	logic [3:0] bit_count;

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy <= 1'b0;
			frame <= '1;
			timer <= '0;
			bit_count <= '0;
		end else if (!busy) begin
			if (send_strobe) begin
				busy <= 1'b1;
				// stop, data LSB first, start
				frame <= {1'b1, send_byte, 1'b0};
				timer <= '0;
				bit_count <= '0;
			end
		end else if (timer == FULL_BIT) begin
			timer <= '0;
			// ones shift in so the line idles high
			frame <= {1'b1, frame[9:1]};
			if (bit_count == 4'd9)
				busy <= 1'b0;
			else
				bit_count <= bit_count + 1'b1;
		end else begin
			timer <= timer + 1'b1;
		end
	end

	assign tx = frame[0];
	assign ready = !busy;

	no_send_when_busy: assert property (@(posedge CLK) disable iff (reset)
		send_strobe |-> ready);

endmodule

`default_nettype wire

// File: logic/uart_receiver.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_receiver import uart_pkg::*; (
	input  logic     CLK,
	input  logic     reset,
	input  logic     rx,
	output rx_byte_t rx_byte,
	output logic     rx_strobe
);

	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int TW = $clog2(CLKS);
	localparam logic [TW-1:0] HALF_BIT = TW'(CLKS / 2 - 1);
	localparam logic [TW-1:0] FULL_BIT = TW'(CLKS - 1);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [TW-1:0] timer;
	logic [2:0] bit_idx;
	logic [7:0] shift;

	always_ff @(posedge CLK) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= RX_IDLE;
			timer <= '0;
			bit_idx <= '0;
			rx_strobe <= 1'b0;
			rx_byte.frame_err <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			rx_byte.frame_err <= 1'b0;
			timer <= timer + 1'b1;
			case (state)
				RX_IDLE: begin
					timer <= '0;
					if (!rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					// glitch filter, start bit must still be low mid-bit
					if (timer == HALF_BIT) begin
						timer <= '0;
						bit_idx <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (timer == FULL_BIT) begin
						timer <= '0;
						shift <= {rx_sync, shift[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (timer == FULL_BIT) begin
						rx_strobe <= 1'b1;
						rx_byte.data <= shift;
						rx_byte.frame_err <= !rx_sync;
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	strobe_single_cycle: assert property (@(posedge CLK) disable iff (reset)
		rx_strobe |=> !rx_strobe);

endmodule

`default_nettype wire

// File: logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

	// frame_err is only ever high in the rx_strobe cycle
	typedef struct packed {
		logic       frame_err;
		logic [7:0] data;
	} rx_byte_t;

	typedef logic [31:0] word_t;

	// led[3] sticky error, led[2:0] word count
	typedef struct packed {
		logic       frame_err;
		logic [2:0] count;
	} led_status_t;

endpackage

`default_nettype wire

// File: logic/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// clock cycles per serial bit, kept short for simulation
`define UART_CLKS_PER_BIT 8

// bytes packed into one word
`define UART_WORD_BYTES 4

// entries in the sum queue
`define UART_QUEUE_DEPTH 4

`endif
